//--- common/cpuTypesPkg.sv
package cpuTypesPkg;

  // ============================================================
  // Widths and basic types
  // ============================================================
  localparam int WORD_W = 32;
  localparam int REG_W  = 5;

  typedef logic [WORD_W-1:0] word_t;     // Data or address word.
  typedef logic [REG_W-1:0]  regAddr_t;  // Register number.
  typedef logic [5:0]        opcode_t;   // Opcode field.
  typedef logic [5:0]        funct_t;    // Funct field.
  typedef logic [4:0]        shamt_t;    // Shift amount.
  typedef logic [3:0]        aluOp_t;    // ALU operation code.

  localparam regAddr_t REG_RA = 5'd31;   // Link register for jal.

  // ============================================================
  // ALU operations
  // ============================================================
  localparam aluOp_t ALU_ADD  = 4'd0;
  localparam aluOp_t ALU_SUB  = 4'd1;
  localparam aluOp_t ALU_AND  = 4'd2;
  localparam aluOp_t ALU_OR   = 4'd3;
  localparam aluOp_t ALU_XOR  = 4'd4;
  localparam aluOp_t ALU_NOR  = 4'd5;
  localparam aluOp_t ALU_SLT  = 4'd6;
  localparam aluOp_t ALU_SLTU = 4'd7;
  localparam aluOp_t ALU_SLL  = 4'd8;
  localparam aluOp_t ALU_SRL  = 4'd9;
  localparam aluOp_t ALU_LUI  = 4'd10;

  // ============================================================
  // Opcode and funct encodings
  // ============================================================
  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_J     = 6'h02;
  localparam opcode_t OP_JAL   = 6'h03;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_BNE   = 6'h05;
  localparam opcode_t OP_ADDIU = 6'h09;
  localparam opcode_t OP_SLTI  = 6'h0A;
  localparam opcode_t OP_ANDI  = 6'h0C;
  localparam opcode_t OP_ORI   = 6'h0D;
  localparam opcode_t OP_XORI  = 6'h0E;
  localparam opcode_t OP_LUI   = 6'h0F;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SW    = 6'h2B;

  localparam funct_t FN_SLL  = 6'h00;
  localparam funct_t FN_SRL  = 6'h02;
  localparam funct_t FN_JR   = 6'h08;
  localparam funct_t FN_ADD  = 6'h20;
  localparam funct_t FN_ADDU = 6'h21;
  localparam funct_t FN_SUB  = 6'h22;
  localparam funct_t FN_SUBU = 6'h23;
  localparam funct_t FN_AND  = 6'h24;
  localparam funct_t FN_OR   = 6'h25;
  localparam funct_t FN_XOR  = 6'h26;
  localparam funct_t FN_NOR  = 6'h27;
  localparam funct_t FN_SLT  = 6'h2A;
  localparam funct_t FN_SLTU = 6'h2B;

  // ============================================================
  // Stage contents
  // ============================================================
  typedef struct packed {
    logic   regDst;    // Destination is rd.
    logic   regWen;
    logic   aluSrc;    // Second operand is the immediate.
    logic   zeroExt;
    logic   shiftSel;  // First operand is shamt.
    logic   memToReg;
    logic   dRen;
    logic   dWen;
    logic   branch;
    logic   bne;
    logic   jmp;
    logic   jl;
    logic   jmpReg;
    aluOp_t aluOp;
  } ctrl_t;

  typedef struct packed {
    ctrl_t ctrl;
    word_t instr;
    word_t pc;
    word_t incPc;
    word_t rdat1;
    word_t rdat2;
    word_t extendOut;
  } idEx_t;

endpackage

//--- logic/controlDecoder.sv
`timescale 1ns/1ns

module controlDecoder
  import cpuTypesPkg::*;
(
  input  word_t instr,
  output ctrl_t ctrl
);

  opcode_t opcode;
  funct_t  funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  // ============================================================
  // Main decode
  // ============================================================
  always_comb
  begin
    ctrl = '0;                          // Unknown encodings stay a bubble.
    case (opcode)
      OP_RTYPE:
      begin
        ctrl.regDst = 1'b1;
        ctrl.regWen = 1'b1;
        case (funct)
          FN_ADD, FN_ADDU: ctrl.aluOp = ALU_ADD;
          FN_SUB, FN_SUBU: ctrl.aluOp = ALU_SUB;
          FN_AND:          ctrl.aluOp = ALU_AND;
          FN_OR:           ctrl.aluOp = ALU_OR;
          FN_XOR:          ctrl.aluOp = ALU_XOR;
          FN_NOR:          ctrl.aluOp = ALU_NOR;
          FN_SLT:          ctrl.aluOp = ALU_SLT;
          FN_SLTU:         ctrl.aluOp = ALU_SLTU;
          FN_SLL:
          begin
            ctrl.shiftSel = 1'b1;       // Shift rt by shamt.
            ctrl.aluOp    = ALU_SLL;
          end
          FN_SRL:
          begin
            ctrl.shiftSel = 1'b1;
            ctrl.aluOp    = ALU_SRL;
          end
          FN_JR:
          begin
            ctrl.regDst = 1'b0;
            ctrl.regWen = 1'b0;         // No write-back for jr.
            ctrl.jmpReg = 1'b1;
          end
          default: ctrl = '0;
        endcase
      end
      OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
      begin
        ctrl.regWen = 1'b1;
        ctrl.aluSrc = 1'b1;
        case (opcode)
          OP_ADDIU: ctrl.aluOp = ALU_ADD;
          OP_SLTI:  ctrl.aluOp = ALU_SLT;
          OP_LUI:   ctrl.aluOp = ALU_LUI;
          OP_ANDI:  ctrl.aluOp = ALU_AND;
          OP_ORI:   ctrl.aluOp = ALU_OR;
          default:  ctrl.aluOp = ALU_XOR;
        endcase
        // Logical immediates are zero extended.
        ctrl.zeroExt = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
      end
      OP_LW:
      begin
        ctrl.regWen   = 1'b1;
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.dRen     = 1'b1;
        ctrl.aluOp    = ALU_ADD;        // Base plus offset.
      end
      OP_SW:
      begin
        ctrl.aluSrc = 1'b1;
        ctrl.dWen   = 1'b1;
        ctrl.aluOp  = ALU_ADD;
      end
      OP_BEQ, OP_BNE:
      begin
        ctrl.branch = 1'b1;
        ctrl.bne    = (opcode == OP_BNE);
        ctrl.aluOp  = ALU_SUB;
      end
      OP_J:
      begin
        ctrl.jmp = 1'b1;
      end
      OP_JAL:
      begin
        ctrl.jmp    = 1'b1;
        ctrl.jl     = 1'b1;             // Link into r31.
        ctrl.regWen = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

//--- logic/registerFile.sv
`timescale 1ns/1ns

module registerFile
  import cpuTypesPkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  logic     wbWen,
  input  regAddr_t wbReg,
  input  word_t    wbData,
  input  regAddr_t rs,
  input  regAddr_t rt,
  output word_t    rdat1,
  output word_t    rdat2
);

  word_t regs [32];   // Entry 0 is never written.
  logic  wbValid;

  assign wbValid = wbWen && (wbReg != '0);  // Writes to r0 are dropped.

  // ============================================================
  // Write port
  // ============================================================
  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wbValid)
    begin
      regs[wbReg] <= wbData;
    end
  end

  // ============================================================
  // Read ports with write-first bypass
  // ============================================================
  assign rdat1 = (wbValid && (wbReg == rs)) ? wbData : regs[rs];
  assign rdat2 = (wbValid && (wbReg == rt)) ? wbData : regs[rt];

endmodule

//--- logic/pipeRegIdEx.sv
`timescale 1ns/1ns

module pipeRegIdEx
  import cpuTypesPkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  enable,
  input  logic  flush,
  input  idEx_t idExIn,
  output idEx_t idExOut
);

  // ============================================================
  // ID/EX stage register
  // ============================================================
  // An all-zero word is a bubble with no write-back, no memory
  // access and no branch. Flush has priority over a stall.
  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      idExOut <= '0;                    // Start out as a bubble.
    end
    else if (flush)
    begin
      idExOut <= '0;                    // Squash the decoded word.
    end
    else if (enable)
    begin
      idExOut <= idExIn;                // Advance.
    end
    // Enable low keeps the current contents.
  end

endmodule

//--- execute/executeStage.sv
`timescale 1ns/1ns

module executeStage
  import cpuTypesPkg::*;
(
  input  idEx_t    idEx,
  output word_t    exResult,
  output word_t    storeData,
  output word_t    branchTarget,
  output regAddr_t destReg,
  output logic     regWen,
  output logic     memToReg,
  output logic     dRen,
  output logic     dWen,
  output logic     branchTaken
);

  ctrl_t    ctrl;
  shamt_t   shamt;
  regAddr_t rd;
  regAddr_t rt;
  word_t    srcA;
  word_t    srcB;
  word_t    aluOut;
  word_t    brTarget;
  word_t    jTarget;
  logic     equal;

  assign ctrl  = idEx.ctrl;
  assign shamt = idEx.instr[10:6];
  assign rt    = idEx.instr[20:16];
  assign rd    = idEx.instr[15:11];

  // ============================================================
  // ALU
  // ============================================================
  assign srcA = ctrl.shiftSel ? {27'b0, shamt} : idEx.rdat1;
  assign srcB = ctrl.aluSrc ? idEx.extendOut : idEx.rdat2;

  always_comb
  begin
    case (ctrl.aluOp)
      ALU_ADD:  aluOut = srcA + srcB;
      ALU_SUB:  aluOut = srcA - srcB;
      ALU_AND:  aluOut = srcA & srcB;
      ALU_OR:   aluOut = srcA | srcB;
      ALU_XOR:  aluOut = srcA ^ srcB;
      ALU_NOR:  aluOut = ~(srcA | srcB);
      ALU_SLT:  aluOut = {31'b0, $signed(srcA) < $signed(srcB)};
      ALU_SLTU: aluOut = {31'b0, srcA < srcB};
      ALU_SLL:  aluOut = srcB << srcA[4:0];   // Shifts work on rt.
      ALU_SRL:  aluOut = srcB >> srcA[4:0];
      ALU_LUI:  aluOut = {srcB[15:0], 16'h0000};
      default:  aluOut = '0;
    endcase
  end

  assign exResult  = ctrl.jl ? idEx.incPc : aluOut;  // jal saves the return address.
  assign storeData = idEx.rdat2;

  // ============================================================
  // Branch resolution and targets
  // ============================================================
  assign equal    = (idEx.rdat1 == idEx.rdat2);
  assign brTarget = idEx.incPc + {idEx.extendOut[29:0], 2'b00};
  assign jTarget  = {idEx.incPc[31:28], idEx.instr[25:0], 2'b00};

  assign branchTaken = ctrl.jmp || ctrl.jmpReg
                    || (ctrl.branch && (ctrl.bne ? !equal : equal));

  assign branchTarget = ctrl.jmpReg ? idEx.rdat1 :
                        ctrl.jmp    ? jTarget :
                                      brTarget;

  // Destination and pass-through controls.
  assign destReg  = ctrl.jl ? REG_RA : (ctrl.regDst ? rd : rt);
  assign regWen   = ctrl.regWen;
  assign memToReg = ctrl.memToReg;
  assign dRen     = ctrl.dRen;
  assign dWen     = ctrl.dWen;

endmodule

//--- logic/decodeExecute.sv
`timescale 1ns/1ns

module decodeExecute
  import cpuTypesPkg::*;
(
  input  logic     CLK,
  input  logic     nRST,
  input  word_t    instr,
  input  word_t    pc,
  input  logic     enable,
  input  logic     flush,
  input  logic     wbWen,
  input  regAddr_t wbReg,
  input  word_t    wbData,
  output word_t    exResult,
  output regAddr_t destReg,
  output logic     regWen,
  output logic     memToReg,
  output logic     dRen,
  output logic     dWen,
  output word_t    storeData,
  output logic     branchTaken,
  output word_t    branchTarget
);

  ctrl_t decCtrl;
  word_t rdat1;
  word_t rdat2;
  word_t incPc;
  word_t extendOut;
  idEx_t idExIn;
  idEx_t idExOut;

  // ============================================================
  // Decode
  // ============================================================
  controlDecoder i_controlDecoder (
    .instr (instr),
    .ctrl  (decCtrl)
  );

  registerFile i_registerFile (
    .CLK    (CLK),
    .nRST   (nRST),
    .wbWen  (wbWen),
    .wbReg  (wbReg),
    .wbData (wbData),
    .rs     (instr[25:21]),
    .rt     (instr[20:16]),
    .rdat1  (rdat1),
    .rdat2  (rdat2)
  );

  assign incPc     = pc + 32'd4;
  assign extendOut = decCtrl.zeroExt ? {16'h0000, instr[15:0]} :
                                       {{16{instr[15]}}, instr[15:0]};  // Sign extend.

  assign idExIn = '{ctrl:      decCtrl,
                    instr:     instr,
                    pc:        pc,
                    incPc:     incPc,
                    rdat1:     rdat1,
                    rdat2:     rdat2,
                    extendOut: extendOut};

  // ============================================================
  // ID/EX register and execute
  // ============================================================
  pipeRegIdEx i_pipeRegIdEx (
    .CLK     (CLK),
    .nRST    (nRST),
    .enable  (enable),
    .flush   (flush),
    .idExIn  (idExIn),
    .idExOut (idExOut)
  );

  executeStage i_executeStage (
    .idEx         (idExOut),
    .exResult     (exResult),
    .storeData    (storeData),
    .branchTarget (branchTarget),
    .destReg      (destReg),
    .regWen       (regWen),
    .memToReg     (memToReg),
    .dRen         (dRen),
    .dWen         (dWen),
    .branchTaken  (branchTaken)
  );

endmodule

//--- test/clockGen.sv
`timescale 1ns/1ns

module clockGen
(
  output logic CLK,
  output logic nRST
);

  initial
  begin
    CLK  = 1'b0;
    nRST = 1'b0;                        // Reset held from time zero.
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;                        // Release away from the rising edge.
  end

  always #10 CLK = ~CLK;                // 20 ns period.

endmodule

//--- test/tbDecodeExecute.sv
`timescale 1ns/1ns

module tbDecodeExecute
  import cpuTypesPkg::*;
;

  localparam int MAX_LINES = 256;

  logic     CLK;
  logic     nRST;
  word_t    instr;
  word_t    pc;
  logic     enable;
  logic     flush;
  logic     wbWen;
  regAddr_t wbReg;
  word_t    wbData;
  word_t    exResult;
  regAddr_t destReg;
  logic     regWen;
  logic     memToReg;
  logic     dRen;
  logic     dWen;
  word_t    storeData;
  logic     branchTaken;
  word_t    branchTarget;

  // One row per golden line, one column per field.
  word_t vec [MAX_LINES][15];
  int    numLines   = 0;
  int    wordErrors = 0;
  int    regErrors  = 0;
  int    bitErrors  = 0;
  int    otherErrors = 0;
  int    cycles     = 0;
  int    cycleLimit = 8 + 20;

  clockGen i_clockGen (
    .CLK  (CLK),
    .nRST (nRST)
  );

  decodeExecute i_decodeExecute (
    .CLK          (CLK),
    .nRST         (nRST),
    .instr        (instr),
    .pc           (pc),
    .enable       (enable),
    .flush        (flush),
    .wbWen        (wbWen),
    .wbReg        (wbReg),
    .wbData       (wbData),
    .exResult     (exResult),
    .destReg      (destReg),
    .regWen       (regWen),
    .memToReg     (memToReg),
    .dRen         (dRen),
    .dWen         (dWen),
    .storeData    (storeData),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget)
  );

  // ============================================================
  // Compare tasks
  // ============================================================
  task automatic checkWord(input string name, input word_t expected, input word_t actual);
    if (actual !== expected)
    begin
      $display("Error %s expected %h actual %h", name, expected, actual);
      wordErrors++;
    end
  endtask

  task automatic checkReg(input string name, input regAddr_t expected, input regAddr_t actual);
    if (actual !== expected)
    begin
      $display("Error %s expected %0d actual %0d", name, expected, actual);
      regErrors++;
    end
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("Error %s expected %b actual %b", name, expected, actual);
      bitErrors++;
    end
  endtask

  // ============================================================
  // Golden file
  // ============================================================
  task automatic loadVectors();
    int    fd;
    int    rc;
    int    fileLine;
    string text;
    word_t f [15];
    fileLine = 0;
    fd = $fopen("test/golden_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the golden vector file test/golden_vectors.txt");
      otherErrors++;
      return;
    end
    while (!$feof(fd) && numLines < MAX_LINES)
    begin
      text = "";
      rc = $fgets(text, fd);
      fileLine++;
      if (rc > 0 && text.len() > 1 && text.getc(0) != "#")
      begin
        rc = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                     f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
        if (rc != 15)
        begin
          $display("Could not read golden file line %0d", fileLine);
          otherErrors++;
        end
        else
        begin
          for (int k = 0; k < 15; k++)
          begin
            vec[numLines][k] = f[k];
          end
          numLines++;
        end
      end
    end
    $fclose(fd);
    if (numLines == 0)
    begin
      $display("The golden vector file holds no vectors");
      otherErrors++;
    end
  endtask

  task automatic driveLine(input int i);
    instr  = vec[i][0];
    pc     = vec[i][1];
    enable = vec[i][2][0];
    flush  = vec[i][3][0];
    wbWen  = vec[i][4][0];
    wbReg  = vec[i][5][4:0];
    wbData = vec[i][6];
  endtask

  task automatic checkLine(input int i);
    string tag;
    tag = $sformatf("vector %0d", i);
    checkWord({tag, " exResult"}, vec[i][7], exResult);
    checkReg({tag, " destReg"}, vec[i][8][4:0], destReg);
    checkBit({tag, " regWen"}, vec[i][9][0], regWen);
    checkBit({tag, " dRen"}, vec[i][10][0], dRen);
    checkBit({tag, " memToReg"}, vec[i][10][0], memToReg);  // Only loads return memory data.
    checkBit({tag, " dWen"}, vec[i][11][0], dWen);
    checkBit({tag, " branchTaken"}, vec[i][12][0], branchTaken);
    checkWord({tag, " branchTarget"}, vec[i][13], branchTarget);
    checkWord({tag, " storeData"}, vec[i][14], storeData);
  endtask

  // ============================================================
  // Watchdog
  // ============================================================
  always @(posedge CLK)
  begin
    cycles++;
    if (cycles > cycleLimit)
    begin
      $display("Timeout after %0d cycles", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // ============================================================
  // Main sequence
  // ============================================================
  initial
  begin
    instr  = 32'hFC000000;              // Unknown opcode, decodes as a bubble.
    pc     = '0;
    enable = 1'b0;                      // First edge after reset holds the reset value.
    flush  = 1'b0;
    wbWen  = 1'b0;
    wbReg  = '0;
    wbData = '0;
    loadVectors();
    cycleLimit = numLines + 8 + 20;

    repeat (4) @(posedge CLK);
    #9;
    checkBit("reset regWen", 1'b0, regWen);
    checkBit("reset memToReg", 1'b0, memToReg);
    checkBit("reset dRen", 1'b0, dRen);
    checkBit("reset dWen", 1'b0, dWen);
    checkBit("reset branchTaken", 1'b0, branchTaken);
    wait (nRST === 1'b1);

    for (int i = 0; i < numLines; i++)
    begin
      @(posedge CLK);
      #2 driveLine(i);                  // Drive after the edge.
      #17 checkLine(i);                 // Check just before the next edge.
    end

    $display("Errors word=%0d reg=%0d bit=%0d other=%0d",
             wordErrors, regErrors, bitErrors, otherErrors);
    if (wordErrors + regErrors + bitErrors + otherErrors == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- test/golden_vectors.txt
# instr pc enable flush wbWen wbReg wbData | expected for the previous capture:
# exResult destReg regWen dRen dWen branchTaken branchTarget storeData
FC000000 00000000 1 0 1 01 00000010 00000000 00 0 0 0 0 00000000 00000000
FC000000 00000000 1 0 1 02 00000020 00000000 00 0 0 0 0 00000004 00000000
FC000000 00000000 1 0 1 03 FFFFFFF0 00000000 00 0 0 0 0 00000004 00000000
FC000000 00000000 1 0 1 04 12345678 00000000 00 0 0 0 0 00000004 00000000
FC000000 00000000 1 0 1 05 00001000 00000000 00 0 0 0 0 00000004 00000000
FC000000 00000000 1 0 1 06 00000020 00000000 00 0 0 0 0 00000004 00000000
FC000000 00000000 1 0 1 07 00400100 00000000 00 0 0 0 0 00000004 00000000
FC000000 00000000 1 0 1 00 DEADBEEF 00000000 00 0 0 0 0 00000004 00000000
00224020 00000100 1 0 0 00 00000000 00000000 00 0 0 0 0 00000004 00000000
00614822 00000104 1 0 0 00 00000000 00000030 08 1 0 0 0 00010184 00000020
00855024 00000108 1 0 0 00 00000000 FFFFFFE0 09 1 0 0 0 00012190 00000010
00225825 0000010C 1 0 0 00 00000000 00001000 0A 1 0 0 0 0001419C 00001000
00856026 00000110 1 0 0 00 00000000 00000030 0B 1 0 0 0 000161A4 00000020
00226827 00000114 1 0 0 00 00000000 12344678 0C 1 0 0 0 000181AC 00001000
0061702A 00000118 1 0 0 00 00000000 FFFFFFCF 0D 1 0 0 0 0001A1B4 00000020
0061782B 0000011C 1 0 0 00 00000000 00000001 0E 1 0 0 0 0001C1C4 00000010
00018100 00000120 1 0 0 00 00000000 00000000 0F 1 0 0 0 0001E1CC 00000010
00048A02 00000124 1 0 0 00 00000000 00000100 10 1 0 0 0 FFFE0524 00000010
24720005 00000128 1 0 0 00 00000000 00123456 11 1 0 0 0 FFFE2930 12345678
3093FF0F 0000012C 1 0 0 00 00000000 FFFFFFF5 12 1 0 0 0 00000140 00000000
34348000 00000130 1 0 0 00 00000000 00005608 13 1 0 0 0 0003FD6C 00000000
3895FFFF 00000134 1 0 0 00 00000000 00008010 14 1 0 0 0 00020134 00000000
2876FFFF 00000138 1 0 0 00 00000000 1234A987 15 1 0 0 0 00040134 00000000
3C17ABCD 0000013C 1 0 0 00 00000000 00000001 16 1 0 0 0 00000138 00000000
0001C020 00000140 1 0 0 00 00000000 ABCD0000 17 1 0 0 0 FFFEB074 00000000
0341C820 00000144 1 0 1 1A 00000100 00000010 18 1 0 0 0 FFFF01C4 00000010
AC250008 00000148 1 0 0 00 00000000 00000110 19 1 0 0 0 FFFF21C8 00000010
8C5BFFFC 0000014C 1 0 0 00 00000000 00000018 05 0 0 1 0 0000016C 00001000
10460003 00000150 1 0 0 00 00000000 0000001C 1B 1 1 0 0 00000140 00000000
10220003 00000154 1 0 0 00 00000000 00000000 06 0 0 0 1 00000160 00000020
1422FFFE 00000158 1 0 0 00 00000000 FFFFFFF0 02 0 0 0 0 00000164 00000020
14460001 0000015C 1 0 0 00 00000000 FFFFFFF0 02 0 0 0 1 00000154 00000020
08100040 10000160 1 0 0 00 00000000 00000000 06 0 0 0 0 00000164 00000020
0C000200 00000170 1 0 0 00 00000000 00000000 10 0 0 0 1 10400100 00000000
00E00008 00000180 1 0 0 00 00000000 00000174 1F 1 0 0 1 00000800 00000000
00224020 00000100 0 0 0 00 00000000 00400100 00 0 0 0 1 00400100 00000000
AC250008 00000148 1 0 0 00 00000000 00400100 00 0 0 0 1 00400100 00000000
00224020 00000100 1 1 0 00 00000000 00000018 05 0 0 1 0 0000016C 00001000
8C5BFFFC 0000014C 1 0 0 00 00000000 00000000 00 0 0 0 0 00000000 00000000
00224020 00000100 0 1 0 00 00000000 0000001C 1B 1 1 0 0 00000140 00000000
FC000000 00000000 1 0 0 00 00000000 00000000 00 0 0 0 0 00000000 00000000
FC000000 00000000 1 0 0 00 00000000 00000000 00 0 0 0 0 00000004 00000000

//--- tb.f
common/cpuTypesPkg.sv
logic/controlDecoder.sv
logic/registerFile.sv
logic/pipeRegIdEx.sv
execute/executeStage.sv
logic/decodeExecute.sv
test/clockGen.sv
test/tbDecodeExecute.sv

//--- run.sh
#!/bin/sh
# Build and run the decode/execute testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tbDecodeExecute \
  -f tb.f \
  -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Test OK$" "$LOG"; then
  exit 0
else
  exit 1
fi
